/* Makefile */
TOP = comb_filter_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
	  -f sources.f --top-module $(TOP) -Mdir obj_dir -o sim

# the run fails unless the pass message shows up on a line of its own.
run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir

/* dv/comb_filter_tb.sv */
`timescale 1ns/1ps

`include "comb_defines.svh"

module comb_filter_tb
  import comb_pkg::*;
;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYC = 4;
  localparam int PHASE_CYC = 200;
  localparam int NUM_PHASES = 6;
  localparam int FILL_SLACK = 6;
  localparam int TOTAL_CYC = NUM_PHASES * (PHASE_CYC + RESET_CYC + 8);
  localparam int UNITY_COEF = 1 << `COEF_FRAC;

  localparam int MODE_ZERO = 0;
  localparam int MODE_UNITY = 1;
  localparam int MODE_RANDOM = 2;
  localparam int MODE_SAT_POS = 3;
  localparam int MODE_SAT_NEG = 4;
  localparam int MODE_OPPOSITE = 5;

  logic CLK;
  logic RESETN;
  sample_t din;
  coef_t coef;
  logic ready;
  comb_out_t dout;
  logic dout_valid;

  int seed;
  int rand_coef;
  int cur_coef;
  int hist[$];
  int out_count = 0;
  int sat_count = 0;
  int err_value = 0;
  int err_other = 0;

  comb_filter i_comb_filter (
    .CLK(CLK),
    .RESETN(RESETN),
    .din(din),
    .coef(coef),
    .ready(ready),
    .dout(dout),
    .dout_valid(dout_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------

  // the tap is the full product shifted right, which rounds toward minus infinity.
  function automatic int scaled_tap(input int x, input int c);
    longint prod;
    prod = longint'(x) * longint'(c);
    return int'(prod >>> `COEF_FRAC);
  endfunction

  function automatic sample_t next_sample(input int mode, input int idx);
    int r;
    int mag;
    sample_t s;
    r = $random(seed);
    mag = 28672 + (r & 32'hfff);
    case (mode)
      MODE_UNITY: s = sample_t'(r >>> 19);
      MODE_SAT_POS: s = sample_t'(mag);
      MODE_SAT_NEG: s = sample_t'(-mag);
      // the sign flips every delay block, so sample n and n-delay differ in sign.
      MODE_OPPOSITE: s = ((idx / `COMB_DELAY) % 2 == 0) ? sample_t'(mag) : sample_t'(-mag);
      default: s = sample_t'(r);
    endcase
    return s;
  endfunction

  task automatic check_output();
    int n;
    int raw;
    int exp_sample;
    logic exp_sat;
    n = `COMB_DELAY + out_count;
    if (n >= hist.size()) begin
      $display("output %0d appeared before sample %0d was accepted", out_count, n);
      err_other++;
    end else begin
      raw = hist[n] + scaled_tap(hist[n - `COMB_DELAY], cur_coef);
      exp_sat = 1'b1;
      if (raw > 32767) begin
        exp_sample = 32767;
      end else if (raw < -32768) begin
        exp_sample = -32768;
      end else begin
        exp_sample = raw;
        exp_sat = 1'b0;
      end
      if (dout.sample !== sample_t'(exp_sample)) begin
        $display("ERR dout.sample n=%0d expected %h got %h", n, sample_t'(exp_sample),
                 dout.sample);
        err_value++;
      end
      if (dout.sat !== exp_sat) begin
        $display("ERR dout.sat n=%0d expected %h got %h", n, exp_sat, dout.sat);
        err_value++;
      end
    end
    if (dout.sat) begin
      sat_count++;
    end
    out_count++;
  endtask

  // all DUT outputs change on the edge, so the values seen here are the settled ones.
  always @(posedge CLK) begin
    if (RESETN) begin
      if (ready) begin
        hist.push_back(int'(din));
      end
      if (dout_valid) begin
        check_output();
      end
    end
  end

  // ------------------------------------------------------------
  // phase control
  // ------------------------------------------------------------
  task automatic check_level(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERR %s expected %h got %h", name, expected, actual);
      err_value++;
    end
  endtask

  task automatic check_counts(input int mode);
    int expected_outs;
    expected_outs = hist.size() - `COMB_DELAY;
    if (out_count > expected_outs || out_count < expected_outs - FILL_SLACK) begin
      $display("phase %0d gave %0d outputs for %0d accepted samples", mode, out_count,
               hist.size());
      err_other++;
    end
    if ((mode == MODE_SAT_POS || mode == MODE_SAT_NEG) && sat_count != out_count) begin
      $display("phase %0d clipped only %0d of %0d outputs", mode, sat_count, out_count);
      err_other++;
    end
    if (mode == MODE_OPPOSITE && sat_count != 0) begin
      $display("phase %0d clipped %0d outputs of opposite-sign pairs", mode, sat_count);
      err_other++;
    end
  endtask

  task automatic run_phase(input int mode, input int c);
    int idx;
    @(posedge CLK);
    RESETN <= 1'b0;
    coef <= coef_t'(c);
    din <= '0;
    repeat (RESET_CYC) @(posedge CLK);
    hist.delete();
    out_count = 0;
    sat_count = 0;
    cur_coef = c;
    RESETN <= 1'b1;
    @(negedge CLK);
    check_level("ready", ready, 1'b0);
    check_level("dout_valid", dout_valid, 1'b0);
    for (idx = 0; idx < PHASE_CYC; idx++) begin
      @(posedge CLK);
      din <= next_sample(mode, idx);
      if (idx == 0) begin
        @(negedge CLK);
        check_level("ready", ready, 1'b1);
      end
    end
    @(negedge CLK);
    check_counts(mode);
  endtask

  task automatic print_counts();
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
  endtask

  initial begin
    seed = 45;
    RESETN = 1'b0;
    din = '0;
    coef = '0;
    run_phase(MODE_ZERO, 0);
    run_phase(MODE_UNITY, UNITY_COEF);
    rand_coef = $random(seed);
    run_phase(MODE_RANDOM, int'(coef_t'(rand_coef)));
    run_phase(MODE_SAT_POS, UNITY_COEF);
    run_phase(MODE_SAT_NEG, UNITY_COEF);
    run_phase(MODE_OPPOSITE, UNITY_COEF);
    @(negedge CLK);
    print_counts();
    if (err_value == 0 && err_other == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // ------------------------------------------------------------
  // watchdog
  // ------------------------------------------------------------
  initial begin
    #((TOTAL_CYC + 100) * CLK_PERIOD);
    $display("watchdog expired before all phases finished");
    print_counts();
    $display("Something failed");
    $finish;
  end

endmodule

/* hw/comb_defines.svh */
`ifndef COMB_DEFINES_SVH
`define COMB_DEFINES_SVH

// sample width of the filter input and output.
`define SAMPLE_W 16

// signed coefficient width and its fraction bits.
`define COEF_W 12
`define COEF_FRAC 10

// distance in samples between the direct sample and the delayed tap.
`define COMB_DELAY 8

`endif

/* hw/comb_filter.sv */
`timescale 1ns/1ps

`include "comb_defines.svh"

module comb_filter
  import comb_pkg::*;
(
  input  logic      CLK,
  input  logic      RESETN,
  input  sample_t   din,
  input  coef_t     coef,
  output logic      ready,
  output comb_out_t dout,
  output logic      dout_valid
);

  sample_t delayed;
  logic delayed_valid;
  tap_pair_t pair;
  logic pair_valid;

  // ------------------------------------------------------------
  // delayed tap
  // ------------------------------------------------------------
  delay_line #(
    .DELAY_CLK(`COMB_DELAY)
  ) i_delay_line (
    .CLK(CLK),
    .RESETN(RESETN),
    .din(din),
    .delayed(delayed),
    .ready(ready),
    .delayed_valid(delayed_valid)
  );

  // ------------------------------------------------------------
  // scale and sum
  // ------------------------------------------------------------
  tap_scaler i_tap_scaler (
    .CLK(CLK),
    .RESETN(RESETN),
    .din(din),
    .delayed(delayed),
    .delayed_valid(delayed_valid),
    .coef(coef),
    .pair(pair),
    .pair_valid(pair_valid)
  );

  comb_output_stage i_comb_output_stage (
    .CLK(CLK),
    .RESETN(RESETN),
    .pair(pair),
    .pair_valid(pair_valid),
    .dout(dout),
    .dout_valid(dout_valid)
  );

endmodule

/* hw/comb_output_stage.sv */
`timescale 1ns/1ps

`include "comb_defines.svh"

module comb_output_stage
  import comb_pkg::*;
(
  input  logic      CLK,
  input  logic      RESETN,
  input  tap_pair_t pair,
  input  logic      pair_valid,
  output comb_out_t dout,
  output logic      dout_valid
);

  localparam int SUM_W = `SAMPLE_W + 3;
  localparam logic signed [SUM_W-1:0] SUM_MAX = SUM_W'((2 ** (`SAMPLE_W - 1)) - 1);
  localparam logic signed [SUM_W-1:0] SUM_MIN = -SUM_MAX - 1;

  logic signed [SUM_W-1:0] sum;
  comb_out_t clipped;
  logic seen_valid;

  // both fields are signed, so they sign-extend to the sum width.
  assign sum = pair.direct + pair.tap;

  always_comb begin
    if (sum > SUM_MAX) begin
      clipped.sample = sample_t'(SUM_MAX);
      clipped.sat = 1'b1;
    end else if (sum < SUM_MIN) begin
      clipped.sample = sample_t'(SUM_MIN);
      clipped.sat = 1'b1;
    end else begin
      clipped.sample = sample_t'(sum);
      clipped.sat = 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      dout <= '0;
      dout_valid <= 1'b0;
      seen_valid <= 1'b0;
    end else begin
      if (pair_valid) begin
        dout <= clipped;
      end
      dout_valid <= pair_valid;
      seen_valid <= seen_valid || dout_valid;
    end
  end

  a_quiet_until_valid: assert property (
    @(posedge CLK) disable iff (!RESETN)
    (!seen_valid && !dout_valid) |-> (dout == '0)
  ) else $error("dout changed before the first valid output");

endmodule

/* hw/comb_pkg.sv */
`include "comb_defines.svh"

package comb_pkg;

  // ------------------------------------------------------------
  // sample and coefficient words
  // ------------------------------------------------------------
  typedef logic signed [`SAMPLE_W-1:0] sample_t;
  typedef logic signed [`COEF_W-1:0] coef_t;

  // ------------------------------------------------------------
  // pipeline words
  // ------------------------------------------------------------

  // the tap keeps two bits of headroom over a sample so the adder can
  // still see an overflow before it clips.
  typedef struct packed {
    sample_t direct;
    logic signed [`SAMPLE_W+1:0] tap;
  } tap_pair_t;

  // sat is set when the sum did not fit and was clipped.
  typedef struct packed {
    sample_t sample;
    logic sat;
  } comb_out_t;

endpackage

/* hw/delay_line.sv */
`timescale 1ns/1ps

module delay_line
  import comb_pkg::*;
#(
  parameter int DELAY_CLK = 8
) (
  input  logic    CLK,
  input  logic    RESETN,
  input  sample_t din,
  output sample_t delayed,
  output logic    ready,
  output logic    delayed_valid
);

  generate
    if (DELAY_CLK <= 1) begin : g_pass

      // a single register already gives one sample of delay.
      always_ff @(posedge CLK) begin
        if (!RESETN) begin
          delayed <= '0;
          delayed_valid <= 1'b0;
          ready <= 1'b0;
        end else begin
          delayed <= din;
          delayed_valid <= ready;
          ready <= 1'b1;
        end
      end

    end else begin : g_fifo

      // the FIFO output register adds the last sample of delay, so reads
      // start one sample before DELAY_CLK samples have gone in.
      localparam int READ_START = DELAY_CLK - 1;
      localparam int CNT_W = $clog2(DELAY_CLK);

      logic full;
      logic not_empty;
      logic write_en;
      logic read_en;
      logic [CNT_W-1:0] delay_cnt;

      assign ready = write_en;

      sample_fifo #(
        .WIDTH($bits(sample_t)),
        .DEPTH(DELAY_CLK)
      ) i_sample_fifo (
        .CLK(CLK),
        .RESETN(RESETN),
        .din(din),
        .we(write_en),
        .re(read_en),
        .dout(delayed),
        .not_empty(not_empty),
        .full(full)
      );

      // ----------------------------------------------------------
      // fill counter that saturates once reading may begin
      // ----------------------------------------------------------
      always_ff @(posedge CLK) begin
        if (!RESETN) begin
          delay_cnt <= '0;
          read_en <= 1'b0;
        end else begin
          if (delay_cnt == CNT_W'(READ_START)) begin
            delay_cnt <= delay_cnt;
            read_en <= 1'b1;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
            read_en <= 1'b0;
          end
        end
      end

      always_ff @(posedge CLK) begin
        if (!RESETN) begin
          write_en <= 1'b0;
        end else begin
          write_en <= !full;
        end
      end

      // the read data register updates on the same edge as this flag.
      always_ff @(posedge CLK) begin
        if (!RESETN) begin
          delayed_valid <= 1'b0;
        end else begin
          delayed_valid <= read_en && not_empty;
        end
      end

      a_valid_after_fill: assert property (
        @(posedge CLK) disable iff (!RESETN)
        $rose(delayed_valid) |-> (delay_cnt == CNT_W'(READ_START))
      ) else $error("delayed_valid rose before the delay was reached");

    end
  endgenerate

endmodule

/* hw/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo
  import comb_pkg::*;
#(
  parameter int WIDTH = 16,
  parameter int DEPTH = 8
) (
  input  logic             CLK,
  input  logic             RESETN,
  input  logic [WIDTH-1:0] din,
  input  logic             we,
  input  logic             re,
  output logic [WIDTH-1:0] dout,
  output logic             not_empty,
  output logic             full
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // pointers wrap at DEPTH, which need not be a power of two.
  function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
    logic [ADDR_W-1:0] nxt;
    if (ptr == ADDR_W'(DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full = (count == CNT_W'(DEPTH));
  assign not_empty = (count != '0);

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[wr_ptr] <= din;
    end
  end

  // ------------------------------------------------------------
  // pointers, occupancy and read data
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      dout <= '0;
    end else begin
      if (we) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (re) begin
        rd_ptr <= next_ptr(rd_ptr);
        dout <= mem[rd_ptr];
      end
      case ({we, re})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // a write into a full buffer is only safe when a read frees the slot
  // on the same edge.
  a_no_overflow: assert property (
    @(posedge CLK) disable iff (!RESETN) (we && full) |-> re
  ) else $error("sample_fifo write while full");

  a_no_underflow: assert property (
    @(posedge CLK) disable iff (!RESETN) re |-> not_empty
  ) else $error("sample_fifo read while empty");

endmodule

/* hw/tap_scaler.sv */
`timescale 1ns/1ps

`include "comb_defines.svh"

module tap_scaler
  import comb_pkg::*;
(
  input  logic      CLK,
  input  logic      RESETN,
  input  sample_t   din,
  input  sample_t   delayed,
  input  logic      delayed_valid,
  input  coef_t     coef,
  output tap_pair_t pair,
  output logic      pair_valid
);

  localparam int PROD_W = `SAMPLE_W + `COEF_W;
  localparam int TAP_W = `SAMPLE_W + 2;

  logic signed [PROD_W-1:0] prod_q;
  logic signed [PROD_W-1:0] prod_shifted;
  sample_t direct_q;
  logic valid_q;

  // ------------------------------------------------------------
  // stage one registers the full-precision product
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      prod_q <= '0;
      direct_q <= '0;
      valid_q <= 1'b0;
    end else begin
      prod_q <= delayed * coef;
      direct_q <= din;
      valid_q <= delayed_valid;
    end
  end

  // dropping the low fraction bits truncates toward minus infinity.
  assign prod_shifted = prod_q >>> `COEF_FRAC;

  // ------------------------------------------------------------
  // stage two scales back to sample units
  // ------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      pair <= '0;
      pair_valid <= 1'b0;
    end else begin
      pair.direct <= direct_q;
      pair.tap <= TAP_W'(prod_shifted);
      pair_valid <= valid_q;
    end
  end

endmodule

/* sources.f */
+incdir+hw
hw/comb_pkg.sv
hw/sample_fifo.sv
hw/delay_line.sv
hw/tap_scaler.sv
hw/comb_output_stage.sv
hw/comb_filter.sv
dv/comb_filter_tb.sv
